// ==== issue_cfg.svh ====
// ------------------
// build-time sizes of the issue stage
// include in any file that needs a queue depth,
// a register count or a counter width
// ------------------
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// instruction queue entries, a power of two, 2 or more
`define ISSUE_IQ_DEPTH 4

// integer register file size
`define ISSUE_NREGS 32

// bits per pending-write counter (saturates at all ones)
`define ISSUE_CNT_W 2

`endif

// ==== issue_cu.sv ====
// ------------------
// issue control unit
// one FSM state per issue class, the popped word enters its state on
// the pop edge, valids toward execute and commit are Mealy on the readies
// special events by age: commit flush, mispredict, fetch fault
// ------------------
`timescale 1ns/1ns

module issue_cu import issue_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  flush_i,
  input  logic  ex_mis_i,
  input  logic  ex_ready_i,
  input  logic  comm_ready_i,
  input  logic  comm_resume_i,
  output logic  ex_valid_o,
  output logic  comm_valid_o,
  output logic  comm_jb_o,
  output logic  comm_fetch_except_o,
  output logic  comm_res_valid_o,
  output logic  mis_flush_o,
  issue_if.cu   iq,
  regstat_if.cu rs
);
  typedef enum logic [3:0] {
    S_RESET,
    S_IDLE,
    S_NONE,
    S_INT,
    S_LUI,
    S_STORE,
    S_BRANCH,
    S_JUMP,
    S_CSR_WAIT,      // rs1 still has writes in flight
    S_CSR,
    S_EXCEPT,        // illegal opcode
    S_FETCH_EXCEPT,
    S_FLUSH,         // one cycle after a mispredict
    S_STALL          // until commit resumes
  } state_t;

  state_t state_q, next_state, v_next, e_next;
  logic   both_ready;
  logic   xfer;       // issue port transfer this cycle
  logic   pop;
  logic   event_req;

  assign both_ready = ex_ready_i & comm_ready_i;
  assign pop        = iq.iq_valid & iq.iq_ready;

  always_comb begin
    case (state_q)
      S_INT, S_STORE, S_BRANCH, S_JUMP:               xfer = both_ready;
      S_NONE, S_LUI, S_CSR, S_EXCEPT, S_FETCH_EXCEPT: xfer = comm_ready_i;
      default:                                        xfer = 1'b0;
    endcase
  end

  // ------------------
  // next state on a popped word
  // ------------------
  always_comb begin
    case (iq.iq_type)
      ISSUE_TYPE_NONE:   v_next = S_NONE;
      ISSUE_TYPE_INT:    v_next = S_INT;
      ISSUE_TYPE_LUI:    v_next = S_LUI;
      ISSUE_TYPE_STORE:  v_next = S_STORE;
      ISSUE_TYPE_BRANCH: v_next = S_BRANCH;
      ISSUE_TYPE_JUMP:   v_next = S_JUMP;
      ISSUE_TYPE_CSR:    v_next = S_CSR_WAIT;
      ISSUE_TYPE_STALL:  v_next = S_STALL;
      default:           v_next = S_EXCEPT;
    endcase
  end

  // special events, oldest first
  assign event_req = flush_i | ex_mis_i | (pop & iq.iq_except);

  always_comb begin
    if (flush_i) e_next = S_IDLE;
    else if (ex_mis_i) e_next = S_FLUSH;
    else e_next = S_FETCH_EXCEPT;
  end

  always_comb begin
    next_state = state_q;  // hold by default
    case (state_q)
      S_RESET: next_state = S_IDLE;
      S_IDLE: begin
        if (pop) next_state = v_next;
      end
      S_NONE, S_INT, S_LUI, S_STORE, S_BRANCH, S_JUMP: begin
        if (pop) next_state = v_next;         // back to back issue
        else if (xfer) next_state = S_IDLE;
      end
      S_CSR_WAIT: begin
        if (rs.rs1_ready) next_state = S_CSR;
      end
      S_CSR, S_EXCEPT, S_FETCH_EXCEPT: begin
        if (xfer) next_state = S_STALL;       // no speculation past these
      end
      S_FLUSH: next_state = S_STALL;
      S_STALL: begin
        if (pop) next_state = v_next;
        else if (comm_resume_i) next_state = S_IDLE;
      end
      default: next_state = S_RESET;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) state_q <= S_RESET;
    else if (event_req) state_q <= e_next;
    else state_q <= next_state;
  end

  // ------------------
  // Mealy outputs
  // ------------------
  always_comb begin
    iq.iq_ready         = 1'b0;
    iq.res_sel_rs1      = 1'b0;
    rs.alloc            = 1'b0;
    ex_valid_o          = 1'b0;
    comm_valid_o        = 1'b0;
    comm_jb_o           = 1'b0;
    comm_fetch_except_o = 1'b0;
    comm_res_valid_o    = 1'b0;
    mis_flush_o         = 1'b0;
    case (state_q)
      S_IDLE: iq.iq_ready = 1'b1;
      S_NONE, S_LUI: begin
        comm_valid_o     = 1'b1;  // held until commit takes it
        comm_res_valid_o = 1'b1;
        iq.iq_ready      = xfer;
        rs.alloc         = xfer & (state_q == S_LUI);
      end
      S_INT, S_STORE, S_BRANCH, S_JUMP: begin
        ex_valid_o   = xfer;      // both sides or neither
        comm_valid_o = xfer;
        iq.iq_ready  = xfer;
        rs.alloc     = xfer & (state_q inside {S_INT, S_JUMP});
        comm_jb_o    = xfer & (state_q inside {S_BRANCH, S_JUMP});
      end
      S_CSR: begin
        comm_valid_o     = 1'b1;
        comm_res_valid_o = 1'b1;
        iq.res_sel_rs1   = 1'b1;
        rs.alloc         = xfer;
      end
      S_EXCEPT: comm_valid_o = 1'b1;
      S_FETCH_EXCEPT: begin
        comm_valid_o        = 1'b1;
        comm_fetch_except_o = 1'b1;
      end
      S_FLUSH: mis_flush_o = 1'b1;
      S_STALL: iq.iq_ready = comm_resume_i;
      default: ;
    endcase
  end

  // queue drops its contents on either flush
  assign iq.q_flush = flush_i | (state_q == S_FLUSH);

endmodule

// ==== issue_if.sv ====
// ------------------
// internal buses of the issue stage
// issue_if links the queue head to the control unit,
// regstat_if ties the register status table to both of them
// ------------------
`timescale 1ns/1ns

// queue <-> control unit
interface issue_if import issue_pkg::*; ();
  logic        iq_valid;     // queue not empty
  logic        iq_except;    // head carries a fetch fault
  issue_type_t iq_type;      // decoded head class
  logic        iq_ready;     // pop the head into the issue register
  logic        res_sel_rs1;  // csr result comes from rs1
  logic        q_flush;      // drop every queued word

  modport iq (
    output iq_valid, iq_except, iq_type,
    input  iq_ready, res_sel_rs1, q_flush
  );

  modport cu (
    input  iq_valid, iq_except, iq_type,
    output iq_ready, res_sel_rs1, q_flush
  );
endinterface

// register status lookup and update
interface regstat_if import issue_pkg::*; ();
  logic     alloc;      // one more write in flight for rd
  reg_idx_t rd;         // from the issue register
  reg_idx_t rs1;        // from the issue register
  logic     rs1_ready;  // no write pending on rs1

  modport rs (
    input  alloc, rd, rs1,
    output rs1_ready
  );

  modport cu (
    output alloc,
    input  rs1_ready
  );

  modport iq (
    output rd, rs1
  );
endinterface

// ==== issue_pkg.sv ====
// ------------------
// types shared by the issue stage blocks
// issue classes, the instruction word with its two field views, opcodes
// pull in with a wildcard import in the module header
// ------------------
package issue_pkg;

  localparam int unsigned WORD_W    = 32;
  localparam int unsigned REG_IDX_W = 5;
  localparam int unsigned OPCODE_W  = 7;
  localparam int unsigned FUNCT3_W  = 3;
  localparam int unsigned FUNCT7_W  = 7;
  localparam int unsigned IMM_I_W   = 12;  // also the zero fill below a u-immediate

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;

  // operation class seen by the control unit
  typedef enum logic [3:0] {
    ISSUE_TYPE_NONE,    // all-zero word
    ISSUE_TYPE_INT,
    ISSUE_TYPE_LUI,
    ISSUE_TYPE_STORE,
    ISSUE_TYPE_BRANCH,
    ISSUE_TYPE_JUMP,
    ISSUE_TYPE_CSR,
    ISSUE_TYPE_STALL,   // fence and friends
    ISSUE_TYPE_EXCEPT   // illegal or fetch fault
  } issue_type_t;

  typedef struct packed {
    logic [FUNCT7_W-1:0] funct7;
    reg_idx_t            rs2;
    reg_idx_t            rs1;
    logic [FUNCT3_W-1:0] funct3;
    reg_idx_t            rd;
    opcode_t             opcode;
  } instr_r_t;

  typedef struct packed {
    logic [IMM_I_W-1:0]  imm;     // top of the u-immediate too
    reg_idx_t            rs1;
    logic [FUNCT3_W-1:0] funct3;
    reg_idx_t            rd;
    opcode_t             opcode;
  } instr_iu_t;

  // one word, two decodes
  typedef union packed {
    instr_r_t  r;
    instr_iu_t iu;
  } instr_t;

  // major opcodes
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_SYSTEM   = 7'b1110011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;

endpackage

// ==== issue_props.sv ====
// ------------------
// handshake and reset rules of the issue control unit
// bound into issue_cu by the testbench
// ------------------
`timescale 1ns/1ns

module issue_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic flush_i,
  input logic ex_mis_i,
  input logic ex_ready_i,
  input logic comm_ready_i,
  input logic ex_valid_o,
  input logic comm_valid_o,
  input logic comm_jb_o,
  input logic comm_fetch_except_o,
  input logic comm_res_valid_o,
  input logic mis_flush_o
);
  int unsigned fail_count = 0;  // failed assertions so far

  // quiet outputs while reset is held
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !(ex_valid_o | comm_valid_o | comm_jb_o | comm_fetch_except_o |
                   comm_res_valid_o | mis_flush_o))
    else begin
      fail_count++;
      $error("issue outputs active during reset");
    end

  // execute and commit take an execute-path word together
  a_ex_with_comm: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ex_valid_o |-> comm_valid_o && ex_ready_i && comm_ready_i)
    else begin
      fail_count++;
      $error("ex_valid_o without both readies and comm_valid_o");
    end

  // a commit offer stays up until commit takes it
  a_comm_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    comm_valid_o && !comm_ready_i && !flush_i && !ex_mis_i |=> comm_valid_o)
    else begin
      fail_count++;
      $error("comm_valid_o dropped before comm_ready_i");
    end

  // a fetch fault taken by commit stalls the stage
  a_fault_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    comm_fetch_except_o && comm_ready_i && !flush_i && !ex_mis_i |=>
      !(ex_valid_o | comm_valid_o))
    else begin
      fail_count++;
      $error("issue continued right after a fetch fault");
    end

  a_mis_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mis_flush_o |=> !mis_flush_o)
    else begin
      fail_count++;
      $error("mis_flush_o longer than one cycle");
    end

endmodule

// ==== issue_queue.sv ====
// ------------------
// instruction FIFO with head decode and the issue register
// the control unit pops the head through iq_ready, the popped word
// then feeds execute, the register status lookup and the result mux
// ------------------
`timescale 1ns/1ns
`include "issue_cfg.svh"

module issue_queue import issue_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   in_valid_i,
  output logic   in_ready_o,
  input  instr_t in_instr_i,
  input  logic   in_except_i,
  input  word_t  rs1_value_i,
  output instr_t ex_instr_o,
  output word_t  comm_res_o,
  issue_if.iq    iq,
  regstat_if.iq  rs
);
  localparam int unsigned DEPTH = `ISSUE_IQ_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  instr_t           mem_instr [DEPTH];  // payload, no reset
  logic [DEPTH-1:0] mem_except;
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [PTR_W:0]   count;
  logic             push, pop;
  instr_t           head;
  logic             head_except;
  issue_type_t      head_type;
  instr_t           ir_instr;           // issue register
  logic             ir_lui;

  // ------------------
  // circular buffer
  // ------------------
  assign in_ready_o = (count != (PTR_W+1)'(DEPTH));  // low only when full
  assign push       = in_valid_i & in_ready_o;
  assign pop        = iq.iq_valid & iq.iq_ready;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_instr[wr_ptr]  <= in_instr_i;
      mem_except[wr_ptr] <= in_except_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (iq.q_flush) begin
      rd_ptr <= wr_ptr;          // empty, but keep a word pushed this cycle
      wr_ptr <= wr_ptr + PTR_W'(push);
      count  <= (PTR_W+1)'(push);
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // ------------------
  // head decode
  // ------------------
  assign head        = mem_instr[rd_ptr];
  assign head_except = iq.iq_valid & mem_except[rd_ptr];

  always_comb begin
    case (head.r.opcode)
      OPC_OP, OPC_OP_IMM: head_type = ISSUE_TYPE_INT;
      OPC_LUI:            head_type = ISSUE_TYPE_LUI;
      OPC_STORE:          head_type = ISSUE_TYPE_STORE;
      OPC_BRANCH:         head_type = ISSUE_TYPE_BRANCH;
      OPC_JAL, OPC_JALR:  head_type = ISSUE_TYPE_JUMP;
      OPC_SYSTEM:         head_type = ISSUE_TYPE_CSR;
      OPC_MISC_MEM:       head_type = ISSUE_TYPE_STALL;
      default:            head_type = ISSUE_TYPE_EXCEPT;  // illegal opcode
    endcase
    if (head == '0) head_type = ISSUE_TYPE_NONE;
    if (head_except) head_type = ISSUE_TYPE_EXCEPT;  // fetch fault wins
  end

  assign iq.iq_valid  = (count != '0);
  assign iq.iq_except = head_except;
  assign iq.iq_type   = head_type;

  // ------------------
  // issue register and result select
  // ------------------
  always_ff @(posedge clk_i) begin
    if (pop) ir_instr <= head;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) ir_lui <= 1'b0;
    else if (pop) ir_lui <= (head_type == ISSUE_TYPE_LUI);
  end

  assign ex_instr_o = ir_instr;
  assign rs.rd      = ir_instr.r.rd;
  assign rs.rs1     = ir_instr.r.rs1;

  // lui gets its u-immediate through the i/u view
  always_comb begin
    if (ir_lui) begin
      comm_res_o = {ir_instr.iu.imm, ir_instr.iu.rs1, ir_instr.iu.funct3, {IMM_I_W{1'b0}}};
    end else if (iq.res_sel_rs1) begin
      comm_res_o = rs1_value_i;  // csr reads rs1
    end else begin
      comm_res_o = '0;
    end
  end

endmodule

// ==== issue_regstat.sv ====
// ------------------
// integer register status, one pending-write counter per register
// alloc from the control unit counts up for rd, commit write-back
// counts down, rs1_ready tells whether rs1 can be read
// ------------------
`timescale 1ns/1ns
`include "issue_cfg.svh"

module issue_regstat import issue_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     comm_wb_valid_i,
  input  reg_idx_t comm_wb_rd_i,
  regstat_if.rs    rs
);
  localparam int unsigned NREGS = `ISSUE_NREGS;
  localparam int unsigned CNT_W = `ISSUE_CNT_W;
  localparam logic [CNT_W-1:0] CNT_MAX = '1;

  logic [NREGS-1:0] cnt_zero;  // no write in flight, per register

  assign cnt_zero[0] = 1'b1;  // x0 never waits

  // ------------------
  // counters for x1 and up
  // ------------------
  for (genvar r = 1; r < NREGS; r++) begin : g_cnt
    logic [CNT_W-1:0] cnt_q;
    logic             inc, dec;

    assign inc = rs.alloc & (rs.rd == reg_idx_t'(r));
    assign dec = comm_wb_valid_i & (comm_wb_rd_i == reg_idx_t'(r));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q <= '0;
      end else if (inc && !dec && cnt_q != CNT_MAX) begin
        cnt_q <= cnt_q + 1'b1;  // saturate at all ones
      end else if (dec && !inc && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // inc and dec together leave the count alone
    end

    assign cnt_zero[r] = (cnt_q == '0);
  end

  // operand lookup for the issue register
  assign rs.rs1_ready = cnt_zero[rs.rs1];

endmodule

// ==== issue_stage.sv ====
// ------------------
// issue stage top level
// queue, register status table and control unit behind plain
// valid/ready ports toward fetch, execute and commit
// ------------------
`timescale 1ns/1ns

module issue_stage import issue_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // fetch side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  instr_t   in_instr_i,
  input  logic     in_except_i,
  // execute side
  output logic     ex_valid_o,
  input  logic     ex_ready_i,
  output instr_t   ex_instr_o,
  input  logic     ex_mis_i,
  // commit side
  output logic     comm_valid_o,
  input  logic     comm_ready_i,
  output logic     comm_jb_o,
  output logic     comm_fetch_except_o,
  output logic     comm_res_valid_o,
  output word_t    comm_res_o,
  input  logic     comm_resume_i,
  input  logic     comm_wb_valid_i,
  input  reg_idx_t comm_wb_rd_i,
  input  logic     flush_i,
  // operand and fetch redirect
  input  word_t    rs1_value_i,
  output logic     mis_flush_o
);
  issue_if   iq_bus ();
  regstat_if rs_bus ();

  issue_queue u_queue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_instr_i  (in_instr_i),
    .in_except_i (in_except_i),
    .rs1_value_i (rs1_value_i),
    .ex_instr_o  (ex_instr_o),
    .comm_res_o  (comm_res_o),
    .iq          (iq_bus.iq),
    .rs          (rs_bus.iq)
  );

  issue_regstat u_regstat (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .comm_wb_valid_i (comm_wb_valid_i),
    .comm_wb_rd_i    (comm_wb_rd_i),
    .rs              (rs_bus.rs)
  );

  // also owns the queue flush
  issue_cu u_cu (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .flush_i             (flush_i),
    .ex_mis_i            (ex_mis_i),
    .ex_ready_i          (ex_ready_i),
    .comm_ready_i        (comm_ready_i),
    .comm_resume_i       (comm_resume_i),
    .ex_valid_o          (ex_valid_o),
    .comm_valid_o        (comm_valid_o),
    .comm_jb_o           (comm_jb_o),
    .comm_fetch_except_o (comm_fetch_except_o),
    .comm_res_valid_o    (comm_res_valid_o),
    .mis_flush_o         (mis_flush_o),
    .iq                  (iq_bus.cu),
    .rs                  (rs_bus.cu)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the issue stage testbench with Verilator
# exit status is zero only when the log holds the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_issue_stage -o tb_issue_stage

# a raised error limit lets the testbench reach its own report
./obj_dir/tb_issue_stage +verilator+error+limit+1000 | tee sim.log

grep -qx "PASS: all tests" sim.log
echo "simulation passed"

// ==== sim.f ====
+incdir+.
issue_pkg.sv
issue_if.sv
issue_queue.sv
issue_regstat.sv
issue_cu.sv
issue_stage.sv
issue_props.sv
tb_issue_stage.sv

// ==== tb_issue_stage.sv ====
// ------------------
// testbench for the issue stage
// random instruction mix from a fixed seed, checked against a queue
// model of the issue order and a model of the register status table
// ------------------
`timescale 1ns/1ns
`include "issue_cfg.svh"

module tb_issue_stage import issue_pkg::*; ();
  localparam int unsigned N_INSTR        = 120;
  localparam int unsigned TIMEOUT_CYCLES = 40 * N_INSTR + 200;
  localparam int unsigned NREGS          = `ISSUE_NREGS;
  localparam int unsigned DEPTH          = `ISSUE_IQ_DEPTH;
  localparam logic [`ISSUE_CNT_W-1:0] CNT_MAX = '1;

  logic     clk_i;
  logic     rst_n_i;
  logic     in_valid_i, in_ready_o, in_except_i;
  instr_t   in_instr_i, ex_instr_o;
  logic     ex_valid_o, ex_ready_i, ex_mis_i;
  logic     comm_valid_o, comm_ready_i, comm_jb_o, comm_fetch_except_o;
  logic     comm_res_valid_o, comm_resume_i, comm_wb_valid_i;
  logic     flush_i, mis_flush_o;
  word_t    comm_res_o, rs1_value_i;
  reg_idx_t comm_wb_rd_i;

  // ------------------
  // model state
  // ------------------
  instr_t                  exp_q [$];          // accepted and not yet issued
  logic                    exc_q [$];
  logic [`ISSUE_CNT_W-1:0] cnt_model [NREGS];  // pending writes per register
  instr_t      cur_word;
  logic        cur_exc;
  logic        have_word = 1'b0;   // word waiting on the input port
  logic        stalled   = 1'b0;   // stage waits for resume
  logic        mis_now   = 1'b0;
  logic        flush_now = 1'b0;
  logic        pulse_due = 1'b0;
  logic        pulse_now = 1'b0;   // mis_flush_o expected this cycle
  int unsigned made = 0;
  int unsigned sent = 0;
  int unsigned cycles = 0;
  int unsigned checks = 0;
  int unsigned mismatches = 0;
  int unsigned other_errors = 0;
  string       test_name = "reset";

  issue_stage dut (.*);

  bind issue_cu issue_props u_props (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycles <= cycles + 1;  // watchdog count

  // ------------------
  // compare tasks
  // ------------------
  task automatic check_instr(string name, instr_t exp, instr_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s %s: expected %h, actual %h at %0t", test_name, name, exp, act, $time);
    end
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s %s: expected %h, actual %h at %0t", test_name, name, exp, act, $time);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s %s: expected %b, actual %b at %0t", test_name, name, exp, act, $time);
    end
  endtask

  // issue class by the opcode table where a fetch fault wins
  function automatic issue_type_t expected_type(instr_t w, logic exc);
    issue_type_t t;
    if (exc) begin
      t = ISSUE_TYPE_EXCEPT;
    end else if (word_t'(w) == '0) begin
      t = ISSUE_TYPE_NONE;
    end else begin
      case (w.r.opcode)
        OPC_OP, OPC_OP_IMM: t = ISSUE_TYPE_INT;
        OPC_LUI:            t = ISSUE_TYPE_LUI;
        OPC_STORE:          t = ISSUE_TYPE_STORE;
        OPC_BRANCH:         t = ISSUE_TYPE_BRANCH;
        OPC_JAL, OPC_JALR:  t = ISSUE_TYPE_JUMP;
        OPC_SYSTEM:         t = ISSUE_TYPE_CSR;
        OPC_MISC_MEM:       t = ISSUE_TYPE_STALL;
        default:            t = ISSUE_TYPE_EXCEPT;
      endcase
    end
    return t;
  endfunction

  // kinds 0-3 go to execute, 4 none, 5 lui, 6 csr, 7 illegal
  function automatic instr_t random_word(int kind);
    instr_t w;
    w       = instr_t'($urandom);
    w.r.rd  = reg_idx_t'($urandom_range(7));  // few registers for many hazards
    w.r.rs1 = reg_idx_t'($urandom_range(7));
    case (kind)
      0:       w.r.opcode = ($urandom_range(1) != 0) ? OPC_OP : OPC_OP_IMM;
      1:       w.r.opcode = OPC_STORE;
      2:       w.r.opcode = OPC_BRANCH;
      3:       w.r.opcode = ($urandom_range(1) != 0) ? OPC_JAL : OPC_JALR;
      4:       w = '0;
      5:       w.r.opcode = OPC_LUI;
      6:       w.r.opcode = OPC_SYSTEM;
      default: w.r.opcode = 7'b1111111;  // no such major opcode
    endcase
    return w;
  endfunction

  task automatic update_regstat(logic alloc, reg_idx_t rd, logic wb, reg_idx_t wr);
    logic inc;
    logic dec;
    for (int r = 1; r < NREGS; r++) begin
      inc = alloc && (rd == reg_idx_t'(r));
      dec = wb && (wr == reg_idx_t'(r));
      if (inc && !dec && cnt_model[r] != CNT_MAX) cnt_model[r] = cnt_model[r] + 1'b1;
      else if (dec && !inc && cnt_model[r] != '0) cnt_model[r] = cnt_model[r] - 1'b1;
    end
  endtask

  task automatic check_reset_outputs();
    check_bit("in_ready_o", 1'b1, in_ready_o);
    check_bit("ex_valid_o", 1'b0, ex_valid_o);
    check_bit("comm_valid_o", 1'b0, comm_valid_o);
    check_bit("mis_flush_o", 1'b0, mis_flush_o);
    check_bit("comm_jb_o", 1'b0, comm_jb_o);
    check_bit("comm_fetch_except_o", 1'b0, comm_fetch_except_o);
    check_bit("comm_res_valid_o", 1'b0, comm_res_valid_o);
  endtask

  // ------------------
  // per-cycle stimulus 2 ns after the edge
  // ------------------
  task automatic drive_cycle();
    int unsigned start;
    int unsigned r;
    int          kind;
    ex_mis_i        = 1'b0;
    flush_i         = 1'b0;
    comm_resume_i   = 1'b0;
    comm_wb_valid_i = 1'b0;
    mis_now         = 1'b0;
    flush_now       = 1'b0;
    pulse_now       = pulse_due;
    pulse_due       = 1'b0;
    ex_ready_i      = ($urandom_range(3) != 0);
    comm_ready_i    = ($urandom_range(3) != 0);
    rs1_value_i     = $urandom;
    // write back one register that has a write in flight
    if ($urandom_range(2) == 0) begin
      start = $urandom_range(NREGS - 1);
      for (int i = 0; i < NREGS; i++) begin
        r = (start + i) % NREGS;
        if (r != 0 && cnt_model[r] != '0 && !comm_wb_valid_i) begin
          comm_wb_valid_i = 1'b1;
          comm_wb_rd_i    = reg_idx_t'(r);
        end
      end
    end
    // mispredict or commit flush in the mixed part only
    if (!pulse_now && !stalled && made > N_INSTR / 2 && made < N_INSTR) begin
      if ($urandom_range(39) == 0) mis_now = 1'b1;
      else if ($urandom_range(59) == 0) flush_now = 1'b1;
    end
    ex_mis_i = mis_now;
    flush_i  = flush_now;
    if (mis_now || flush_now) begin
      ex_ready_i   = 1'b0;  // nothing leaves in the event cycle
      comm_ready_i = 1'b0;
    end
    if (stalled && !pulse_now && $urandom_range(3) == 0) comm_resume_i = 1'b1;
    if (!have_word && made < N_INSTR && $urandom_range(3) != 0) begin
      kind      = (made < N_INSTR / 2) ? $urandom_range(3) : $urandom_range(7);
      cur_word  = random_word(kind);
      cur_exc   = (made >= N_INSTR / 2) && ($urandom_range(9) == 0);
      have_word = 1'b1;
      made++;
    end
    in_valid_i  = have_word && !(mis_now || flush_now || pulse_now);
    in_instr_i  = cur_word;
    in_except_i = cur_exc;
  endtask

  // ------------------
  // per-cycle checks and model update at the falling edge
  // ------------------
  task automatic observe_cycle();
    instr_t      w;
    word_t       raw;
    logic        exc;
    logic        alloc;
    reg_idx_t    alloc_rd;
    issue_type_t t;
    alloc    = 1'b0;
    alloc_rd = '0;
    check_bit("mis_flush_o", pulse_now, mis_flush_o);
    // room in the model queue means room in the DUT queue
    if (!pulse_now && exp_q.size() < DEPTH) check_bit("in_ready_o", 1'b1, in_ready_o);
    if (stalled) check_bit("valid during stall", 1'b0, ex_valid_o | comm_valid_o);
    if (ex_valid_o) check_bit("comm_valid_o with ex_valid_o", 1'b1, comm_valid_o);
    // a csr may only show up once its rs1 has no write pending
    if (comm_valid_o && exp_q.size() != 0) begin
      w = exp_q[0];
      if (expected_type(w, exc_q[0]) == ISSUE_TYPE_CSR)
        check_bit("csr rs1 ready", 1'b1, cnt_model[w.r.rs1] == '0);
    end
    if (comm_valid_o && comm_ready_i) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("error: %s: a word was issued with nothing outstanding at %0t",
                 test_name, $time);
      end else begin
        w   = exp_q.pop_front();
        exc = exc_q.pop_front();
        raw = word_t'(w);
        t   = expected_type(w, exc);
        check_bit("ex_valid_o", t inside {ISSUE_TYPE_INT, ISSUE_TYPE_STORE,
                  ISSUE_TYPE_BRANCH, ISSUE_TYPE_JUMP}, ex_valid_o);
        check_instr("issued word", w, ex_instr_o);
        check_bit("comm_jb_o", t inside {ISSUE_TYPE_BRANCH, ISSUE_TYPE_JUMP}, comm_jb_o);
        check_bit("comm_fetch_except_o", exc, comm_fetch_except_o);
        check_bit("comm_res_valid_o", t inside {ISSUE_TYPE_NONE, ISSUE_TYPE_LUI,
                  ISSUE_TYPE_CSR}, comm_res_valid_o);
        if (t == ISSUE_TYPE_LUI) check_word("lui result", {raw[31:12], 12'h000}, comm_res_o);
        else if (t == ISSUE_TYPE_CSR) check_word("csr result", rs1_value_i, comm_res_o);
        else if (t == ISSUE_TYPE_NONE) check_word("none result", '0, comm_res_o);
        if (t inside {ISSUE_TYPE_INT, ISSUE_TYPE_JUMP, ISSUE_TYPE_LUI, ISSUE_TYPE_CSR}) begin
          alloc    = 1'b1;  // rd gets a write in flight
          alloc_rd = w.r.rd;
        end
        if (t inside {ISSUE_TYPE_CSR, ISSUE_TYPE_EXCEPT}) stalled = 1'b1;
      end
    end
    if (in_valid_i && in_ready_o) begin
      exp_q.push_back(in_instr_i);
      exc_q.push_back(in_except_i);
      sent++;
      have_word = 1'b0;
    end
    update_regstat(alloc, alloc_rd, comm_wb_valid_i, comm_wb_rd_i);
    if (mis_now) begin
      pulse_due = 1'b1;
      stalled   = 1'b1;  // flush state then stall
      exp_q.delete();
      exc_q.delete();
    end
    if (flush_now) begin
      stalled = 1'b0;    // back to idle
      exp_q.delete();
      exc_q.delete();
    end
    if (comm_resume_i) stalled = 1'b0;
  endtask

  task automatic run_cycle();
    @(posedge clk_i);
    #2;
    drive_cycle();
    @(negedge clk_i);
    observe_cycle();
  endtask

  task automatic finish_run();
    int unsigned assert_fails;
    assert_fails = dut.u_cu.u_props.fail_count;
    $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
             checks, mismatches, other_errors, assert_fails);
    if (mismatches + other_errors + assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // ------------------
  // main sequence
  // ------------------
  initial begin
    void'($urandom(58));
    rst_n_i         = 1'b0;
    in_valid_i      = 1'b0;
    in_instr_i      = '0;
    in_except_i     = 1'b0;
    ex_ready_i      = 1'b0;
    ex_mis_i        = 1'b0;
    comm_ready_i    = 1'b0;
    comm_resume_i   = 1'b0;
    comm_wb_valid_i = 1'b0;
    comm_wb_rd_i    = '0;
    flush_i         = 1'b0;
    rs1_value_i     = '0;
    cur_word        = '0;
    cur_exc         = 1'b0;
    for (int r = 0; r < NREGS; r++) cnt_model[r] = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_reset_outputs();        // still in reset
    @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;               // four edges in reset
    @(negedge clk_i);
    check_reset_outputs();        // reset state of the FSM
    test_name = "exec stream";
    while (sent < N_INSTR || exp_q.size() != 0 || stalled) begin
      if (made > N_INSTR / 2) test_name = "mixed stream";
      run_cycle();
    end
    test_name = "drain";          // nothing may issue from here on
    repeat (10) run_cycle();
    finish_run();
  end

  initial begin
    wait (cycles >= TIMEOUT_CYCLES);
    $display("error: timeout after %0d cycles, %0d of %0d words accepted",
             cycles, sent, N_INSTR);
    other_errors++;
    finish_run();
  end

endmodule
